//--- design/rv_defs.svh
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// Data path width
`define RV_XLEN 32

// Architectural registers, x0 included
`define RV_NUM_REGS 32

`define FQ_DEPTH 2  // Fetch queue entries

`endif

//--- design/rv_pkg.sv
`default_nettype none

package rv_pkg;

  typedef logic [31:0] instr;    // Raw instruction word
  typedef logic [4:0]  reg_idx;
  typedef logic [31:0] gpreg;    // Register value

  // Op class, from opcode bits 6:2
  typedef enum logic [3:0] {
    INSTR_LOAD,
    INSTR_MISC_MEM,
    INSTR_OP_IMM,
    INSTR_AUIPC,
    INSTR_STORE,
    INSTR_OP,
    INSTR_LUI,
    INSTR_BRANCH,
    INSTR_JALR,
    INSTR_JAL,
    INSTR_SYSTEM,
    INSTR_INVAL
  } instr_op;

  typedef enum logic [2:0] {
    INSTR_R,
    INSTR_I,
    INSTR_S,
    INSTR_B,
    INSTR_U,
    INSTR_J
  } instr_fmt;

  // Decoded record as handed to execute
  typedef struct packed {
    instr_op     op;
    reg_idx      rs1;
    reg_idx      rs2;
    reg_idx      rd;
    gpreg        imm;      // Sign extended per format
    logic [2:0]  funct3;
    gpreg        rs1_val;
    gpreg        rs2_val;
  } decoded_instr;

endpackage

`default_nettype wire

//--- design/regfile_read_if.sv
`default_nettype none
`timescale 1ns/10ps

// Two read ports, values come back in the same cycle
interface regfile_read_if;
  rv_pkg::reg_idx rs_idx0;
  rv_pkg::reg_idx rs_idx1;
  rv_pkg::gpreg   rs_val0;
  rv_pkg::gpreg   rs_val1;

  modport decoder (
    output rs_idx0, rs_idx1,
    input  rs_val0, rs_val1
  );

  modport regfile (
    input  rs_idx0, rs_idx1,
    output rs_val0, rs_val1
  );
endinterface

`default_nettype wire

//--- design/fetch_queue.sv
`default_nettype none
`timescale 1ns/10ps
`include "rv_defs.svh"

module fetch_queue (
  input  logic         clk,
  input  logic         rst_n,
  input  logic         flush,
  input  logic         instr_valid,
  output logic         instr_ready,
  input  rv_pkg::instr instr,
  output logic         fq_valid,
  input  logic         fq_ready,
  output rv_pkg::instr fq_instr
);

  localparam int PTR_W = (`FQ_DEPTH > 1) ? $clog2(`FQ_DEPTH) : 1;
  localparam int CNT_W = $clog2(`FQ_DEPTH + 1);

  rv_pkg::instr     mem [`FQ_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push;
  logic             pop;

  // Wraps at depth, so non power of two depths work too
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(`FQ_DEPTH - 1))
      return '0;
    else
      return ptr + 1'b1;
  endfunction

  // Input refused while full or flushing
  assign instr_ready = (count != CNT_W'(`FQ_DEPTH)) && !flush;
  assign fq_valid    = (count != '0);
  assign fq_instr    = mem[rd_ptr];  // Head of queue

  assign push = instr_valid && instr_ready;
  assign pop  = fq_valid && fq_ready;

  always_ff @(posedge clk) begin
    if (!rst_n || flush) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push)
        wr_ptr <= next_ptr(wr_ptr);
      if (pop)
        rd_ptr <= next_ptr(rd_ptr);
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // Idle or push and pop together
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push)
      mem[wr_ptr] <= instr;
  end

  a_count_bound: assert property (@(posedge clk) disable iff (!rst_n)
    count <= CNT_W'(`FQ_DEPTH))
    else $error("fetch_queue holds more entries than its depth");

endmodule

`default_nettype wire

//--- design/instr_decode.sv
`default_nettype none
`timescale 1ns/10ps

module instr_decode (
  input  logic                 fetch_valid,
  output logic                 fetch_ready,
  input  rv_pkg::instr         fetch_instr,
  regfile_read_if.decoder      rf,
  output logic                 dec_valid,
  input  logic                 dec_ready,
  output rv_pkg::decoded_instr dec
);

  rv_pkg::instr_op  op;
  rv_pkg::instr_fmt fmt;
  logic             has_rs1;
  logic             has_rs2;
  logic             has_rd;
  logic             sign_bit;
  rv_pkg::reg_idx   rs1;
  rv_pkg::reg_idx   rs2;
  rv_pkg::reg_idx   rd;
  rv_pkg::gpreg     imm;

  // Pure combinational stage, handshake passes straight through
  assign dec_valid   = fetch_valid;
  assign fetch_ready = dec_ready;

  // Op class and format from opcode bits 6:2
  always_comb begin
    op  = rv_pkg::INSTR_INVAL;
    fmt = rv_pkg::INSTR_I;  // Don't care for invalid ops
    if (fetch_instr[1:0] == 2'b11) begin  // No compressed quadrants
      case (fetch_instr[6:2])
        5'b00000: begin
          op  = rv_pkg::INSTR_LOAD;
          fmt = rv_pkg::INSTR_I;
        end
        5'b00011: begin
          op  = rv_pkg::INSTR_MISC_MEM;  // FENCE flags live in imm
          fmt = rv_pkg::INSTR_I;
        end
        5'b00100: begin
          op  = rv_pkg::INSTR_OP_IMM;
          fmt = rv_pkg::INSTR_I;
        end
        5'b00101: begin
          op  = rv_pkg::INSTR_AUIPC;
          fmt = rv_pkg::INSTR_U;
        end
        5'b01000: begin
          op  = rv_pkg::INSTR_STORE;
          fmt = rv_pkg::INSTR_S;
        end
        5'b01100: begin
          op  = rv_pkg::INSTR_OP;
          fmt = rv_pkg::INSTR_R;
        end
        5'b01101: begin
          op  = rv_pkg::INSTR_LUI;
          fmt = rv_pkg::INSTR_U;
        end
        5'b11000: begin
          op  = rv_pkg::INSTR_BRANCH;
          fmt = rv_pkg::INSTR_B;
        end
        5'b11001: begin
          op  = rv_pkg::INSTR_JALR;
          fmt = rv_pkg::INSTR_I;
        end
        5'b11011: begin
          op  = rv_pkg::INSTR_JAL;
          fmt = rv_pkg::INSTR_J;
        end
        5'b11100: begin
          op  = rv_pkg::INSTR_SYSTEM;
          fmt = rv_pkg::INSTR_I;
        end
        default: begin
          op  = rv_pkg::INSTR_INVAL;
          fmt = rv_pkg::INSTR_I;
        end
      endcase
    end
  end

  // Register fields the format lacks read as x0
  assign has_rs1 = (fmt != rv_pkg::INSTR_U) && (fmt != rv_pkg::INSTR_J);
  assign has_rs2 = has_rs1 && (fmt != rv_pkg::INSTR_I);
  assign has_rd  = (fmt != rv_pkg::INSTR_S) && (fmt != rv_pkg::INSTR_B);

  assign rs1 = has_rs1 ? fetch_instr[19:15] : '0;
  assign rs2 = has_rs2 ? fetch_instr[24:20] : '0;
  assign rd  = has_rd  ? fetch_instr[11:7]  : '0;

  assign sign_bit = fetch_instr[31];

  // R shares the I layout, so imm[11:5] carries funct7
  always_comb begin
    case (fmt)
      rv_pkg::INSTR_I, rv_pkg::INSTR_R:
        imm = {{20{sign_bit}}, fetch_instr[31:20]};
      rv_pkg::INSTR_S:
        imm = {{20{sign_bit}}, fetch_instr[31:25], fetch_instr[11:7]};
      rv_pkg::INSTR_B:
        imm = {{20{sign_bit}}, fetch_instr[7], fetch_instr[30:25],
               fetch_instr[11:8], 1'b0};
      rv_pkg::INSTR_U:
        imm = {fetch_instr[31:12], 12'b0};
      rv_pkg::INSTR_J:
        imm = {{12{sign_bit}}, fetch_instr[19:12], fetch_instr[20],
               fetch_instr[30:21], 1'b0};
      default:
        imm = '0;
    endcase
  end

  // Operand read, same cycle
  assign rf.rs_idx0 = rs1;
  assign rf.rs_idx1 = rs2;

  always_comb begin
    dec.op      = op;
    dec.rs1     = rs1;
    dec.rs2     = rs2;
    dec.rd      = rd;
    dec.imm     = imm;
    dec.funct3  = fetch_instr[14:12];
    dec.rs1_val = rf.rs_val0;
    dec.rs2_val = rf.rs_val1;
  end

endmodule

`default_nettype wire

//--- design/reg_file.sv
`default_nettype none
`timescale 1ns/10ps
`include "rv_defs.svh"

module reg_file (
  input  logic           clk,
  input  logic           rst_n,
  regfile_read_if.regfile rf,
  input  logic           wb_en,
  input  rv_pkg::reg_idx wb_rd,
  input  rv_pkg::gpreg   wb_data
);

  // Entry 0 is cleared by reset and never written
  rv_pkg::gpreg regs [`RV_NUM_REGS];

  // Write bypass first, then the array
  function automatic rv_pkg::gpreg read_port(input rv_pkg::reg_idx idx);
    if (wb_en && (wb_rd != '0) && (wb_rd == idx))
      return wb_data;
    else
      return regs[idx];
  endfunction

  always_comb begin
    rf.rs_val0 = read_port(rf.rs_idx0);
    rf.rs_val1 = read_port(rf.rs_idx1);
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < `RV_NUM_REGS; i++)
        regs[i] <= '0;
    end else if (wb_en && (wb_rd != '0)) begin  // Writes to x0 dropped
      regs[wb_rd] <= wb_data;
    end
  end

  a_x0_zero: assert property (@(posedge clk) disable iff (!rst_n)
    ((rf.rs_idx0 == '0) |-> (rf.rs_val0 == '0)) and
    ((rf.rs_idx1 == '0) |-> (rf.rs_val1 == '0)))
    else $error("x0 read returned a nonzero value");

endmodule

`default_nettype wire

//--- design/decode_out_reg.sv
`default_nettype none
`timescale 1ns/10ps

module decode_out_reg (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 flush,
  input  logic                 dec_valid,
  output logic                 dec_ready,
  input  rv_pkg::decoded_instr dec,
  output logic                 out_valid,
  input  logic                 out_ready,
  output rv_pkg::decoded_instr out_data
);

  logic load;

  // Accepts when empty or draining this cycle
  assign dec_ready = !out_valid || out_ready;
  assign load      = dec_valid && dec_ready;

  always_ff @(posedge clk) begin
    if (!rst_n || flush)
      out_valid <= 1'b0;
    else if (load)
      out_valid <= 1'b1;
    else if (out_ready)
      out_valid <= 1'b0;  // Handed off, nothing new
  end

  always_ff @(posedge clk) begin
    if (load)
      out_data <= dec;
  end

  // Record held while downstream stalls
  a_hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (out_valid && !out_ready) |=> $stable(out_data))
    else $error("decoded record changed while stalled");

endmodule

`default_nettype wire

//--- design/rv_decode_top.sv
`default_nettype none
`timescale 1ns/10ps
`include "rv_defs.svh"

module rv_decode_top (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             flush,
  input  logic                             instr_valid,
  output logic                             instr_ready,
  input  logic [`RV_XLEN-1:0]              instr,
  input  logic                             wb_en,
  input  logic [$clog2(`RV_NUM_REGS)-1:0]  wb_rd,
  input  logic [`RV_XLEN-1:0]              wb_data,
  output logic                             out_valid,
  input  logic                             out_ready,
  output rv_pkg::instr_op                  out_op,
  output logic [$clog2(`RV_NUM_REGS)-1:0]  out_rs1,
  output logic [$clog2(`RV_NUM_REGS)-1:0]  out_rs2,
  output logic [$clog2(`RV_NUM_REGS)-1:0]  out_rd,
  output logic [`RV_XLEN-1:0]              out_imm,
  output logic [2:0]                       out_funct3,
  output logic [`RV_XLEN-1:0]              out_rs1_val,
  output logic [`RV_XLEN-1:0]              out_rs2_val
);

  logic                 fq_valid;
  logic                 fq_ready;
  rv_pkg::instr         fq_instr;
  logic                 dec_valid;
  logic                 dec_ready;
  rv_pkg::decoded_instr dec;
  rv_pkg::decoded_instr out_data;

  regfile_read_if rf_if ();

  fetch_queue i_fetch_queue (
    .clk         (clk),
    .rst_n       (rst_n),
    .flush       (flush),
    .instr_valid (instr_valid),
    .instr_ready (instr_ready),
    .instr       (instr),
    .fq_valid    (fq_valid),
    .fq_ready    (fq_ready),
    .fq_instr    (fq_instr)
  );

  instr_decode i_instr_decode (
    .fetch_valid (fq_valid),
    .fetch_ready (fq_ready),
    .fetch_instr (fq_instr),
    .rf          (rf_if.decoder),
    .dec_valid   (dec_valid),
    .dec_ready   (dec_ready),
    .dec         (dec)
  );

  reg_file i_reg_file (
    .clk     (clk),
    .rst_n   (rst_n),
    .rf      (rf_if.regfile),
    .wb_en   (wb_en),
    .wb_rd   (wb_rd),
    .wb_data (wb_data)
  );

  decode_out_reg i_decode_out_reg (
    .clk       (clk),
    .rst_n     (rst_n),
    .flush     (flush),
    .dec_valid (dec_valid),
    .dec_ready (dec_ready),
    .dec       (dec),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_data)
  );

  // Record split into plain output fields
  assign out_op      = out_data.op;
  assign out_rs1     = out_data.rs1;
  assign out_rs2     = out_data.rs2;
  assign out_rd      = out_data.rd;
  assign out_imm     = out_data.imm;
  assign out_funct3  = out_data.funct3;
  assign out_rs1_val = out_data.rs1_val;
  assign out_rs2_val = out_data.rs2_val;

endmodule

`default_nettype wire

//--- dv/tb_rv_decode.sv
`default_nettype none
`timescale 1ns/10ps

module tb_rv_decode;

  typedef struct {
    logic [31:0] op;
    logic [31:0] rd;
    logic [31:0] rs1;
    logic [31:0] rs2;
    logic [31:0] imm;
    logic [31:0] funct3;
    logic [31:0] rs1_val;
    logic [31:0] rs2_val;
  } exp_item;

  logic        clk;
  logic        rst_n;
  logic        flush;
  logic        instr_valid;
  logic        instr_ready;
  logic [31:0] instr;
  logic        wb_en;
  logic [4:0]  wb_rd;
  logic [31:0] wb_data;
  logic        out_valid;
  logic        out_ready;
  rv_pkg::instr_op out_op;
  logic [4:0]  out_rs1;
  logic [4:0]  out_rs2;
  logic [4:0]  out_rd;
  logic [31:0] out_imm;
  logic [2:0]  out_funct3;
  logic [31:0] out_rs1_val;
  logic [31:0] out_rs2_val;

  exp_item     exp_q[$];
  logic [31:0] reg_model [32];    // Reference register array
  string       kind_q[$];
  logic [31:0] fld [0:63][0:6];
  int          n_cases;
  logic        stall_hold;        // Forces out_ready low
  logic [31:0] lfsr_state;
  logic        prev_stall;
  exp_item     held;              // Outputs seen in the last stalled cycle

  rv_decode_top i_rv_decode_top (
    .clk         (clk),
    .rst_n       (rst_n),
    .flush       (flush),
    .instr_valid (instr_valid),
    .instr_ready (instr_ready),
    .instr       (instr),
    .wb_en       (wb_en),
    .wb_rd       (wb_rd),
    .wb_data     (wb_data),
    .out_valid   (out_valid),
    .out_ready   (out_ready),
    .out_op      (out_op),
    .out_rs1     (out_rs1),
    .out_rs2     (out_rs2),
    .out_rd      (out_rd),
    .out_imm     (out_imm),
    .out_funct3  (out_funct3),
    .out_rs1_val (out_rs1_val),
    .out_rs2_val (out_rs2_val)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Galois form, polynomial x^32+x^22+x^2+x+1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0])
      return (s >> 1) ^ 32'h80200003;
    else
      return s >> 1;
  endfunction

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERR @%0t: %s got %h expected %h", $time, name, got, exp);
      $display("TEST RESULT: FAIL");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  // Current DUT output fields as one record
  function automatic exp_item sample_outputs();
    exp_item s;
    s.op      = 32'(out_op);
    s.rd      = 32'(out_rd);
    s.rs1     = 32'(out_rs1);
    s.rs2     = 32'(out_rs2);
    s.imm     = out_imm;
    s.funct3  = 32'(out_funct3);
    s.rs1_val = out_rs1_val;
    s.rs2_val = out_rs2_val;
    return s;
  endfunction

  task automatic compare_fields(input string tag, input exp_item got, input exp_item exp);
    check({tag, " op"}, got.op, exp.op);
    check({tag, " rd"}, got.rd, exp.rd);
    check({tag, " rs1"}, got.rs1, exp.rs1);
    check({tag, " rs2"}, got.rs2, exp.rs2);
    check({tag, " imm"}, got.imm, exp.imm);
    check({tag, " funct3"}, got.funct3, exp.funct3);
    check({tag, " rs1_val"}, got.rs1_val, exp.rs1_val);
    check({tag, " rs2_val"}, got.rs2_val, exp.rs2_val);
  endtask

  // Random back-pressure, about one stall cycle in four
  initial begin
    logic b0;
    logic b1;
    lfsr_state = 32'he3c7;
    forever begin
      @(posedge clk);
      #1;
      lfsr_state = lfsr_step(lfsr_state);
      b0 = lfsr_state[0];
      lfsr_state = lfsr_step(lfsr_state);
      b1 = lfsr_state[0];
      out_ready = !stall_hold && (b0 || b1);
    end
  end

  // Sampled mid-cycle, away from the edge
  always @(negedge clk) begin
    exp_item e;
    if (rst_n) begin
      if (prev_stall && out_valid && !flush)
        compare_fields("held", sample_outputs(), held);
      prev_stall = out_valid && !out_ready && !flush;
      held       = sample_outputs();
      if (out_valid && out_ready) begin
        if (exp_q.size() == 0) begin
          $display("Output handed off with no instruction pending at %0t", $time);
          $display("TEST RESULT: FAIL");
          $fatal(1, "extra output");
        end
        e = exp_q.pop_front();
        compare_fields("out", sample_outputs(), e);
      end
    end
  end

  task automatic load_cases();
    int    fd;
    int    code;
    string line;
    string tag;
    logic [31:0] v [0:6];
    fd = $fopen("dv/decode_cases.txt", "r");
    if (fd == 0) begin
      $display("Could not open the case file dv/decode_cases.txt");
      $display("TEST RESULT: FAIL");
      $fatal(1, "no case file");
    end
    while (!$feof(fd)) begin
      code = $fgets(line, fd);
      if (code <= 1 || line.substr(0, 0) == "#")
        continue;
      code = $sscanf(line, "%s %h %h %h %h %h %h %h", tag,
                     v[0], v[1], v[2], v[3], v[4], v[5], v[6]);
      if (code < 2)
        continue;
      kind_q.push_back(tag);
      for (int k = 0; k < 7; k++)
        fld[n_cases][k] = v[k];
      n_cases++;
    end
    $fclose(fd);
  endtask

  task automatic drain();
    while (exp_q.size() != 0)
      @(negedge clk);
  endtask

  task automatic write_reg(input logic [4:0] idx, input logic [31:0] data);
    @(posedge clk);
    #1;
    wb_en   = 1'b1;
    wb_rd   = idx;
    wb_data = data;
    @(posedge clk);
    #1;
    wb_en = 1'b0;
    if (idx != 5'd0)
      reg_model[idx] = data;  // x0 stays zero
  endtask

  task automatic send_instr(input logic [31:0] data);
    @(posedge clk);
    #1;
    instr_valid = 1'b1;
    instr       = data;
    do
      @(negedge clk);
    while (!instr_ready);
    @(posedge clk);
    #1;
    instr_valid = 1'b0;
  endtask

  task automatic expect_case(input int i);
    exp_item e;
    e.op      = fld[i][1];
    e.rd      = fld[i][2];
    e.rs1     = fld[i][3];
    e.rs2     = fld[i][4];
    e.imm     = fld[i][5];
    e.funct3  = fld[i][6];
    e.rs1_val = reg_model[fld[i][3][4:0]];
    e.rs2_val = reg_model[fld[i][4][4:0]];
    exp_q.push_back(e);
  endtask

  // Two copies go in flight, one held in the output stage
  task automatic flush_case(input logic [31:0] data);
    drain();
    @(negedge clk);
    stall_hold = 1'b1;
    @(posedge clk);
    send_instr(data);
    send_instr(data);
    @(negedge clk);
    check("out_valid before flush", 32'(out_valid), 32'd1);
    @(posedge clk);
    #1;
    flush = 1'b1;
    @(posedge clk);
    #1;
    flush = 1'b0;
    @(negedge clk);
    check("out_valid after flush", 32'(out_valid), 32'd0);
    stall_hold = 1'b0;
  endtask

  initial begin
    rst_n       = 1'b0;
    flush       = 1'b0;
    instr_valid = 1'b0;
    instr       = '0;
    wb_en       = 1'b0;
    wb_rd       = '0;
    wb_data     = '0;
    out_ready   = 1'b0;
    stall_hold  = 1'b0;
    prev_stall  = 1'b0;
    n_cases     = 0;
    for (int r = 0; r < 32; r++)
      reg_model[r] = '0;
    load_cases();
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(negedge clk);
    check("out_valid after reset", 32'(out_valid), 32'd0);
    check("instr_ready after reset", 32'(instr_ready), 32'd1);
    for (int i = 0; i < n_cases; i++) begin
      case (kind_q[i])
        "W": begin
          drain();
          write_reg(fld[i][0][4:0], fld[i][1]);
        end
        "I": begin
          expect_case(i);
          send_instr(fld[i][0]);
        end
        "F": flush_case(fld[i][0]);
        default: ;
      endcase
    end
    drain();
    repeat (3) @(posedge clk);
    @(negedge clk);
    check("out_valid when idle", 32'(out_valid), 32'd0);  // No leftover copy
    $display("TEST RESULT: PASS");
    $finish;
  end

  // Hang guard, budget grows with the number of case lines
  initial begin
    @(posedge rst_n);
    #(n_cases * 200 * 10 + 200);
    $display("Simulation hung, cases did not finish in the allowed time");
    $display("TEST RESULT: FAIL");
    $fatal(1, "timeout");
  end

endmodule

`default_nettype wire

//--- dv/decode_cases.txt
# W idx value | I instr op rd rs1 rs2 imm funct3 | F instr (flushed away)
# All values hex, op numbered as in the op class enum
W 01 00001111
W 02 fffffff0
W 05 deadbeef
W 00 12345678
W 1f 80000000
I fff08193 2 03 01 00 ffffffff 0
I 00208233 5 04 01 02 00000002 0
I 40228333 5 06 05 02 00000402 0
I 0082a383 0 07 05 00 00000008 2
I fe20ae23 4 00 01 02 fffffffc 2
I fe208ce3 7 00 01 02 fffffff8 0
I 00029863 7 00 05 00 00000010 1
I abcde437 6 08 00 00 abcde000 6
I 00001497 3 09 00 00 00001000 1
I ffdff0ef 9 01 00 00 fffffffc 7
I 0010006f 9 00 00 00 00000800 0
I 00008067 8 00 01 00 00000000 0
I 00000073 a 00 00 00 00000000 0
I 0ff0000f 1 00 00 00 000000ff 0
I 12345678 b 0c 08 00 00000123 5
I 005f8533 5 0a 1f 05 00000005 0
I 0000007f b 00 00 00 00000000 0
I 000005b3 5 0b 00 00 00000000 0
W 01 7ffffffe
I 00208233 5 04 01 02 00000002 0
F 00108093
I fff08193 2 03 01 00 ffffffff 0
I 005f8533 5 0a 1f 05 00000005 0

//--- project.f
+incdir+design
design/rv_pkg.sv
design/regfile_read_if.sv
design/fetch_queue.sv
design/instr_decode.sv
design/reg_file.sv
design/decode_out_reg.sv
design/rv_decode_top.sv
dv/tb_rv_decode.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
TOP       ?= tb_rv_decode
FILELIST  ?= project.f
LOG       ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)
